// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_i3c_config
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST))) common/i3c_cfg_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+common
common/i3c_cfg_pkg.sv
common/csr_if.sv
hw/csr_regs/i3c_csr_regs.sv
hw/configuration.sv
hw/bus_ctrl_fsm.sv
hw/i3c_config_top.sv
testbench/tb_i3c_config.sv

// File: common/csr_if.sv
// Interface csr_if with the decoded register fields and its modports
`timescale 1ns/100ps

interface csr_if;

  // HC_CONTROL fields
  logic       bus_enable;
  logic       resume;
  logic       abort;
  logic       i2c_dev_present;

  // PIO_CONTROL fields
  logic       pio_enable;
  logic       pio_rs;
  logic       pio_abort;

  // STBY_CR_CONTROL fields
  logic [1:0] stby_cr_enable_init;
  logic       target_xact_enable;

  // Register file side
  modport regs (
    output bus_enable, resume, abort, i2c_dev_present,
    output pio_enable, pio_rs, pio_abort,
    output stby_cr_enable_init, target_xact_enable
  );

  // Consumer side
  modport cfg (
    input bus_enable, resume, abort, i2c_dev_present,
    input pio_enable, pio_rs, pio_abort,
    input stby_cr_enable_init, target_xact_enable
  );

endinterface

// File: common/i3c_cfg_consts.svh
// Register data and address widths, register addresses and field bit positions
`ifndef I3C_CFG_CONSTS_SVH
`define I3C_CFG_CONSTS_SVH

// Register bus widths
`define CSR_DW 32
`define CSR_AW 2

// Register map
`define ADDR_HC_CONTROL      2'd0
`define ADDR_PIO_CONTROL     2'd1
`define ADDR_STBY_CR_CONTROL 2'd2
`define ADDR_STATUS          2'd3

// HC_CONTROL fields
`define BUS_ENABLE      0
`define RESUME          1
`define ABORT           2
`define I2C_DEV_PRESENT 3

// PIO_CONTROL fields
`define PIO_ENABLE 0
`define PIO_RS     1
`define PIO_ABORT  2

// STBY_CR_CONTROL fields, init field is two bits
`define STBY_INIT_LSB  0
`define TARGET_XACT_EN 2

// STATUS fields, both two bits wide
`define STATUS_STATE_LSB 0
`define STATUS_PHY_LSB   4

`endif

// File: common/i3c_cfg_pkg.sv
// Role, PHY select and bus state enums and the core configuration struct
package i3c_cfg_pkg;

  // Active role of the core
  // Codes line up with the PHY select codes
  typedef enum logic [1:0] {
    role_i2c_ctrl = 2'd0,
    role_i3c_ctrl = 2'd1,
    role_i2c_tgt  = 2'd2,
    role_i3c_tgt  = 2'd3
  } core_role_e;

  // PHY multiplexer select
  typedef enum logic [1:0] {
    phy_i2c_ctrl = 2'd0,
    phy_i3c_ctrl = 2'd1,
    phy_i2c_tgt  = 2'd2,
    phy_i3c_tgt  = 2'd3
  } phy_sel_e;

  // Controller bus state
  // Code 3 is never entered
  typedef enum logic [1:0] {
    bus_idle    = 2'd0,
    bus_running = 2'd1,
    bus_halted  = 2'd2
  } bus_state_e;

  // Core configuration seen by the bus engine and PHY
  // Exactly one of the four enables is high
  typedef struct packed {
    logic     i2c_active_en;
    logic     i3c_active_en;
    logic     i2c_standby_en;
    logic     i3c_standby_en;
    // Matches the active role
    phy_sel_e phy_mux_select;
    // Target transaction interface enable
    logic     tti_enable;
  } core_config_t;

endpackage

// File: hw/bus_ctrl_fsm.sv
// Module bus_ctrl_fsm: controller state machine, PIO run level and queue flush
`timescale 1ns/100ps

module bus_ctrl_fsm (
  input  logic                    clk_i,
  input  logic                    rst,
  csr_if.cfg                      cfg,
  input  logic                    halt_req,
  output i3c_cfg_pkg::bus_state_e bus_state,
  output logic                    pio_run,
  output logic                    queue_flush
);

  i3c_cfg_pkg::bus_state_e state_d;

  // Next state
  always_comb begin
    state_d = bus_state;
    if (!cfg.bus_enable) begin
      // Disable wins from any state
      state_d = i3c_cfg_pkg::bus_idle;
    end else begin
      case (bus_state)
        i3c_cfg_pkg::bus_idle: begin
          state_d = i3c_cfg_pkg::bus_running;
        end
        i3c_cfg_pkg::bus_running: begin
          // halt_req from the bus core acts this edge
          if (cfg.abort || halt_req) begin
            state_d = i3c_cfg_pkg::bus_halted;
          end
        end
        i3c_cfg_pkg::bus_halted: begin
          if (cfg.resume) begin
            state_d = i3c_cfg_pkg::bus_running;
          end
        end
        default: state_d = i3c_cfg_pkg::bus_idle;
      endcase
    end
  end

  // State and PIO queue controls
  // pio_run and the flush follow the new state, same edge
  always_ff @(posedge clk_i) begin
    if (rst) begin
      bus_state   <= i3c_cfg_pkg::bus_idle;
      pio_run     <= 1'b0;
      queue_flush <= 1'b0;
    end else begin
      bus_state   <= state_d;
      pio_run     <= (state_d == i3c_cfg_pkg::bus_running) &&
                     cfg.pio_enable && !cfg.pio_abort;
      // Flush on PIO reset or halt entry
      queue_flush <= cfg.pio_rs ||
                     ((state_d == i3c_cfg_pkg::bus_halted) &&
                      (bus_state != i3c_cfg_pkg::bus_halted));
    end
  end

endmodule

// File: hw/configuration.sv
// Module configuration: role decode into the registered core configuration
`timescale 1ns/100ps

module configuration (
  input  logic                      clk_i,
  input  logic                      rst,
  csr_if.cfg                        cfg,
  output i3c_cfg_pkg::core_config_t core_config
);

  i3c_cfg_pkg::core_role_e   role;
  i3c_cfg_pkg::core_config_t config_d;

  // Role from standby init and legacy device fields
  always_comb begin
    case (cfg.stby_cr_enable_init)
      2'd1:    role = i3c_cfg_pkg::role_i3c_tgt;
      2'd2:    role = i3c_cfg_pkg::role_i2c_tgt;
      // 0 and 3 keep an active controller
      default: role = cfg.i2c_dev_present ? i3c_cfg_pkg::role_i2c_ctrl
                                          : i3c_cfg_pkg::role_i3c_ctrl;
    endcase
  end

  // One-hot enables and PHY select from role
  always_comb begin
    config_d = '0;
    case (role)
      i3c_cfg_pkg::role_i2c_ctrl: begin
        config_d.i2c_active_en  = 1'b1;
        config_d.phy_mux_select = i3c_cfg_pkg::phy_i2c_ctrl;
      end
      i3c_cfg_pkg::role_i3c_ctrl: begin
        config_d.i3c_active_en  = 1'b1;
        config_d.phy_mux_select = i3c_cfg_pkg::phy_i3c_ctrl;
      end
      i3c_cfg_pkg::role_i2c_tgt: begin
        config_d.i2c_standby_en = 1'b1;
        config_d.phy_mux_select = i3c_cfg_pkg::phy_i2c_tgt;
      end
      default: begin
        config_d.i3c_standby_en = 1'b1;
        config_d.phy_mux_select = i3c_cfg_pkg::phy_i3c_tgt;
      end
    endcase
    // TTI only meaningful as a target
    config_d.tti_enable = cfg.target_xact_enable &
                          (config_d.i2c_standby_en | config_d.i3c_standby_en);
  end

  // Registered outputs, reset lands on the I3C controller
  always_ff @(posedge clk_i) begin
    if (rst) begin
      core_config                <= '0;
      core_config.i3c_active_en  <= 1'b1;
      core_config.phy_mux_select <= i3c_cfg_pkg::phy_i3c_ctrl;
    end else begin
      core_config <= config_d;
    end
  end

endmodule

// File: hw/csr_regs/i3c_csr_regs.sv
// Module i3c_csr_regs: control registers, pulse bits, status word and read path
`timescale 1ns/100ps
`include "i3c_cfg_consts.svh"

module i3c_csr_regs (
  input  logic                   clk_i,
  input  logic                   rst,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  logic [`CSR_AW-1:0]     addr,
  input  logic [`CSR_DW-1:0]     wdata,
  input  i3c_cfg_pkg::bus_state_e bus_state,
  input  i3c_cfg_pkg::phy_sel_e  phy_mux_select,
  output logic [`CSR_DW-1:0]     rdata,
  csr_if.regs                    regs
);

  // HC_CONTROL
  logic       bus_enable_q;
  logic       resume_q;
  logic       abort_q;
  logic       i2c_dev_present_q;
  // PIO_CONTROL
  logic       pio_enable_q;
  logic       pio_rs_q;
  logic       pio_abort_q;
  // STBY_CR_CONTROL
  logic [1:0] stby_init_q;
  logic       target_xact_q;

  logic [`CSR_DW-1:0] rd_word;

  // Write path
  always_ff @(posedge clk_i) begin
    if (rst) begin
      bus_enable_q      <= 1'b0;
      resume_q          <= 1'b0;
      abort_q           <= 1'b0;
      i2c_dev_present_q <= 1'b0;
      pio_enable_q      <= 1'b0;
      pio_rs_q          <= 1'b0;
      pio_abort_q       <= 1'b0;
      stby_init_q       <= 2'b00;
      target_xact_q     <= 1'b0;
    end else begin
      // Pulse bits live for one cycle unless rewritten
      resume_q <= 1'b0;
      abort_q  <= 1'b0;
      pio_rs_q <= 1'b0;
      if (wr_en) begin
        case (addr)
          `ADDR_HC_CONTROL: begin
            bus_enable_q      <= wdata[`BUS_ENABLE];
            resume_q          <= wdata[`RESUME];
            abort_q           <= wdata[`ABORT];
            i2c_dev_present_q <= wdata[`I2C_DEV_PRESENT];
          end
          `ADDR_PIO_CONTROL: begin
            pio_enable_q <= wdata[`PIO_ENABLE];
            pio_rs_q     <= wdata[`PIO_RS];
            pio_abort_q  <= wdata[`PIO_ABORT];
          end
          `ADDR_STBY_CR_CONTROL: begin
            stby_init_q   <= wdata[`STBY_INIT_LSB +: 2];
            target_xact_q <= wdata[`TARGET_XACT_EN];
          end
          // STATUS is read only
          default: ;
        endcase
      end
    end
  end

  // Read mux, unlisted bits stay 0
  always_comb begin
    rd_word = '0;
    case (addr)
      `ADDR_HC_CONTROL: begin
        rd_word[`BUS_ENABLE]      = bus_enable_q;
        rd_word[`RESUME]          = resume_q;
        rd_word[`ABORT]           = abort_q;
        rd_word[`I2C_DEV_PRESENT] = i2c_dev_present_q;
      end
      `ADDR_PIO_CONTROL: begin
        rd_word[`PIO_ENABLE] = pio_enable_q;
        rd_word[`PIO_RS]     = pio_rs_q;
        rd_word[`PIO_ABORT]  = pio_abort_q;
      end
      `ADDR_STBY_CR_CONTROL: begin
        rd_word[`STBY_INIT_LSB +: 2] = stby_init_q;
        rd_word[`TARGET_XACT_EN]     = target_xact_q;
      end
      default: begin
        rd_word[`STATUS_STATE_LSB +: 2] = bus_state;
        rd_word[`STATUS_PHY_LSB +: 2]   = phy_mux_select;
      end
    endcase
  end

  // Read data captured on rd_en, held otherwise
  always_ff @(posedge clk_i) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= rd_word;
    end
  end

  // Fields out to consumers
  assign regs.bus_enable          = bus_enable_q;
  assign regs.resume              = resume_q;
  assign regs.abort               = abort_q;
  assign regs.i2c_dev_present     = i2c_dev_present_q;
  assign regs.pio_enable          = pio_enable_q;
  assign regs.pio_rs              = pio_rs_q;
  assign regs.pio_abort           = pio_abort_q;
  assign regs.stby_cr_enable_init = stby_init_q;
  assign regs.target_xact_enable  = target_xact_q;

endmodule

// File: hw/i3c_config_top.sv
// Module i3c_config_top: register file, configuration and bus control
`timescale 1ns/100ps
`include "i3c_cfg_consts.svh"

module i3c_config_top (
  input  logic               clk_i,
  input  logic               rst,
  input  logic               wr_en,
  input  logic               rd_en,
  input  logic [`CSR_AW-1:0] addr,
  input  logic [`CSR_DW-1:0] wdata,
  input  logic               halt_req,
  output logic [`CSR_DW-1:0] rdata,
  output logic [1:0]         phy_mux_select,
  output logic               i2c_active_en,
  output logic               i3c_active_en,
  output logic               i2c_standby_en,
  output logic               i3c_standby_en,
  output logic               tti_enable,
  output logic               pio_run,
  output logic               queue_flush,
  output logic [1:0]         bus_state
);

  i3c_cfg_pkg::core_config_t core_cfg;
  i3c_cfg_pkg::bus_state_e   state_w;

  // Decoded register fields
  csr_if csr_if_i ();

  i3c_csr_regs regs_i (
    .clk_i          (clk_i),
    .rst            (rst),
    .wr_en          (wr_en),
    .rd_en          (rd_en),
    .addr           (addr),
    .wdata          (wdata),
    .bus_state      (state_w),
    .phy_mux_select (core_cfg.phy_mux_select),
    .rdata          (rdata),
    .regs           (csr_if_i.regs)
  );

  configuration config_i (
    .clk_i       (clk_i),
    .rst         (rst),
    .cfg         (csr_if_i.cfg),
    .core_config (core_cfg)
  );

  bus_ctrl_fsm bus_ctrl_i (
    .clk_i       (clk_i),
    .rst         (rst),
    .cfg         (csr_if_i.cfg),
    .halt_req    (halt_req),
    .bus_state   (state_w),
    .pio_run     (pio_run),
    .queue_flush (queue_flush)
  );

  // Core configuration onto plain ports
  assign i2c_active_en  = core_cfg.i2c_active_en;
  assign i3c_active_en  = core_cfg.i3c_active_en;
  assign i2c_standby_en = core_cfg.i2c_standby_en;
  assign i3c_standby_en = core_cfg.i3c_standby_en;
  assign phy_mux_select = core_cfg.phy_mux_select;
  assign tti_enable     = core_cfg.tti_enable;
  assign bus_state      = state_w;

endmodule

// File: testbench/tb_i3c_config.sv
// Testbench tb_i3c_config: clock, reset, stimulus table, register readback and timeout
`timescale 1ns/100ps
`include "i3c_cfg_consts.svh"

module tb_i3c_config;

  // One table row: write, then expected outputs two cycles later
  typedef struct packed {
    logic [`CSR_AW-1:0] addr;
    logic [`CSR_DW-1:0] data;
    logic               halt;
    logic [3:0]         en;     // i2c_act, i3c_act, i2c_stby, i3c_stby
    logic [1:0]         phy;
    logic               tti;
    logic [1:0]         state;
    logic               run;
    logic               flush;
  } entry_t;

  localparam int NUM_ENTRIES    = 24;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 8 + 100;

  logic               clk_i;
  logic               rst;
  logic               wr_en;
  logic               rd_en;
  logic [`CSR_AW-1:0] addr;
  logic [`CSR_DW-1:0] wdata;
  logic               halt_req;
  logic [`CSR_DW-1:0] rdata;
  logic [1:0]         phy_mux_select;
  logic               i2c_active_en;
  logic               i3c_active_en;
  logic               i2c_standby_en;
  logic               i3c_standby_en;
  logic               tti_enable;
  logic               pio_run;
  logic               queue_flush;
  logic [1:0]         bus_state;

  entry_t      stim [NUM_ENTRIES];
  integer      seed;
  int unsigned cycle_count;

  i3c_config_top dut_i (
    .clk_i          (clk_i),
    .rst            (rst),
    .wr_en          (wr_en),
    .rd_en          (rd_en),
    .addr           (addr),
    .wdata          (wdata),
    .halt_req       (halt_req),
    .rdata          (rdata),
    .phy_mux_select (phy_mux_select),
    .i2c_active_en  (i2c_active_en),
    .i3c_active_en  (i3c_active_en),
    .i2c_standby_en (i2c_standby_en),
    .i3c_standby_en (i3c_standby_en),
    .tti_enable     (tti_enable),
    .pio_run        (pio_run),
    .queue_flush    (queue_flush),
    .bus_state      (bus_state)
  );

  // 10 ns clock
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  // Bits that belong to a field, the rest is free for random fill
  function automatic logic [31:0] field_mask(input logic [`CSR_AW-1:0] a);
    case (a)
      `ADDR_HC_CONTROL:
        field_mask = (1 << `BUS_ENABLE) | (1 << `RESUME) | (1 << `ABORT) |
                     (1 << `I2C_DEV_PRESENT);
      `ADDR_PIO_CONTROL:
        field_mask = (1 << `PIO_ENABLE) | (1 << `PIO_RS) | (1 << `PIO_ABORT);
      `ADDR_STBY_CR_CONTROL:
        field_mask = (3 << `STBY_INIT_LSB) | (1 << `TARGET_XACT_EN);
      // STATUS takes no write at all
      default:
        field_mask = 32'h0;
    endcase
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic write_reg(input logic [`CSR_AW-1:0] a, input logic [31:0] d,
                           input logic halt);
    wr_en    = 1'b1;
    addr     = a;
    wdata    = d;
    halt_req = halt;
    @(negedge clk_i);
    wr_en    = 1'b0;
    halt_req = 1'b0;
    wdata    = '0;
  endtask

  // Read captured at one rising edge, compared at the next falling edge
  task automatic read_expect(input logic [`CSR_AW-1:0] a, input logic [31:0] exp,
                             input string what);
    rd_en = 1'b1;
    addr  = a;
    @(negedge clk_i);
    rd_en = 1'b0;
    check_value(rdata, exp, what);
  endtask

  task automatic run_entry(input int i);
    entry_t     e;
    logic [31:0] d;
    e = stim[i];
    // Random fill outside the fields must not matter
    d = e.data | ($random(seed) & ~field_mask(e.addr));
    write_reg(e.addr, d, e.halt);
    @(negedge clk_i);
    check_value({i2c_active_en, i3c_active_en, i2c_standby_en, i3c_standby_en},
                e.en, $sformatf("entry %0d enables", i));
    check_value(phy_mux_select, e.phy, $sformatf("entry %0d phy_mux_select", i));
    check_value(tti_enable, e.tti, $sformatf("entry %0d tti_enable", i));
    check_value(bus_state, e.state, $sformatf("entry %0d bus_state", i));
    check_value(pio_run, e.run, $sformatf("entry %0d pio_run", i));
    check_value(queue_flush, e.flush, $sformatf("entry %0d queue_flush", i));
    // Flush is a single-cycle pulse
    @(negedge clk_i);
    check_value(queue_flush, 1'b0, $sformatf("entry %0d queue_flush after pulse", i));
  endtask

  task automatic load_stim();
    // Role decoding with the bus disabled
    stim[0]  = '{`ADDR_STBY_CR_CONTROL, 32'h4, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[1]  = '{`ADDR_HC_CONTROL,      32'h8, 1'b0, 4'b1000, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[2]  = '{`ADDR_STBY_CR_CONTROL, 32'h5, 1'b0, 4'b0001, 2'd3, 1'b1, 2'd0, 1'b0, 1'b0};
    stim[3]  = '{`ADDR_STBY_CR_CONTROL, 32'h6, 1'b0, 4'b0010, 2'd2, 1'b1, 2'd0, 1'b0, 1'b0};
    stim[4]  = '{`ADDR_STBY_CR_CONTROL, 32'h2, 1'b0, 4'b0010, 2'd2, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[5]  = '{`ADDR_HC_CONTROL,      32'h0, 1'b0, 4'b0010, 2'd2, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[6]  = '{`ADDR_STBY_CR_CONTROL, 32'h1, 1'b0, 4'b0001, 2'd3, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[7]  = '{`ADDR_STBY_CR_CONTROL, 32'h7, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[8]  = '{`ADDR_HC_CONTROL,      32'h8, 1'b0, 4'b1000, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[9]  = '{`ADDR_STBY_CR_CONTROL, 32'h4, 1'b0, 4'b1000, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[10] = '{`ADDR_HC_CONTROL,      32'h0, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    // Bus state and PIO control as I3C controller
    stim[11] = '{`ADDR_PIO_CONTROL,     32'h1, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[12] = '{`ADDR_HC_CONTROL,      32'h1, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b0};
    stim[13] = '{`ADDR_HC_CONTROL,      32'h5, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd2, 1'b0, 1'b1};
    stim[14] = '{`ADDR_HC_CONTROL,      32'h3, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b0};
    stim[15] = '{`ADDR_PIO_CONTROL,     32'h5, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b0, 1'b0};
    stim[16] = '{`ADDR_PIO_CONTROL,     32'h1, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b0};
    stim[17] = '{`ADDR_PIO_CONTROL,     32'h3, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b1};
    // halt_req acts at the write edge, its flush is over by the check
    stim[18] = '{`ADDR_HC_CONTROL,      32'h1, 1'b1, 4'b0100, 2'd1, 1'b0, 2'd2, 1'b0, 1'b0};
    stim[19] = '{`ADDR_HC_CONTROL,      32'h3, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b0};
    stim[20] = '{`ADDR_HC_CONTROL,      32'h0, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    stim[21] = '{`ADDR_HC_CONTROL,      32'h1, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd1, 1'b1, 1'b0};
    stim[22] = '{`ADDR_HC_CONTROL,      32'h0, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    // STATUS write, all random, changes nothing
    stim[23] = '{`ADDR_STATUS,          32'h0, 1'b0, 4'b0100, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
  endtask

  initial begin
    seed        = 30561;
    cycle_count = 0;
    rst         = 1'b1;
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    addr        = '0;
    wdata       = '0;
    halt_req    = 1'b0;
    load_stim();

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst = 1'b0;

    // Reset state
    check_value({i2c_active_en, i3c_active_en, i2c_standby_en, i3c_standby_en},
                4'b0100, "reset enables");
    check_value(phy_mux_select, 2'd1, "reset phy_mux_select");
    check_value(tti_enable, 1'b0, "reset tti_enable");
    check_value(bus_state, 2'd0, "reset bus_state");
    check_value(pio_run, 1'b0, "reset pio_run");
    check_value(queue_flush, 1'b0, "reset queue_flush");
    read_expect(`ADDR_HC_CONTROL, 32'h0, "reset HC_CONTROL");
    read_expect(`ADDR_PIO_CONTROL, 32'h0, "reset PIO_CONTROL");
    read_expect(`ADDR_STBY_CR_CONTROL, 32'h0, "reset STBY_CR_CONTROL");
    read_expect(`ADDR_STATUS, 32'h10, "reset STATUS");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(i);
    end

    // Readback of what the table left behind
    read_expect(`ADDR_HC_CONTROL, 32'h0, "HC_CONTROL readback");
    read_expect(`ADDR_PIO_CONTROL, 32'h1, "PIO_CONTROL readback");
    read_expect(`ADDR_STBY_CR_CONTROL, 32'h4, "STBY_CR_CONTROL readback");
    read_expect(`ADDR_STATUS, 32'h10, "STATUS idle readback");

    // Pulse bits visible for one cycle only
    write_reg(`ADDR_HC_CONTROL, 32'h7, 1'b0);
    read_expect(`ADDR_HC_CONTROL, 32'h7, "HC_CONTROL pulse bits");
    read_expect(`ADDR_HC_CONTROL, 32'h1, "HC_CONTROL after pulse");
    read_expect(`ADDR_STATUS, 32'h11, "STATUS running readback");

    // STATUS is read only
    write_reg(`ADDR_STATUS, 32'hffff_ffff, 1'b0);
    read_expect(`ADDR_STATUS, 32'h11, "STATUS after write");
    read_expect(`ADDR_HC_CONTROL, 32'h1, "HC_CONTROL after STATUS write");
    // rdata holds without rd_en, even with the address on another register
    addr = `ADDR_STBY_CR_CONTROL;
    @(negedge clk_i);
    check_value(rdata, 32'h1, "rdata hold");

    $display("=== PASS ===");
    $finish;
  end

endmodule
